// File: mc_cmd_pkg.sv
// Command opcode and default sizes shared by the memory controller blocks
package mc_cmd_pkg;

    // One command moves one word
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mc_op_e;

    // Defaults, overridden through module parameters from the top level
    localparam int AWIDTH_DEF    = 6;
    localparam int DWIDTH_DEF    = 32;
    localparam int CMD_DEPTH_DEF = 4;

    // Cycles from a queue pop to read data
    localparam int RD_LATENCY = 2;

endpackage

// File: mc_test_pkg.sv
// Self-test state encoding and the pseudorandom word sequence
package mc_test_pkg;

    typedef enum logic [1:0] {
        GEN_IDLE  = 2'd0,
        GEN_WRITE = 2'd1,
        GEN_READ  = 2'd2,
        GEN_DRAIN = 2'd3
    } gen_state_e;

    localparam logic [31:0] LFSR_SEED = 32'h1D87_C3A5;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Galois step, shifting right
    function automatic logic [31:0] lfsr_step(input logic [31:0] cur);
        if (cur[0]) begin
            return (cur >> 1) ^ LFSR_TAPS;
        end
        return cur >> 1;
    endfunction

endpackage

// File: host_cmd_port.sv
// Host port that turns single-word host requests into memory commands
`timescale 1ns/1ns

module host_cmd_port #(
    parameter int AWIDTH = mc_cmd_pkg::AWIDTH_DEF,
    parameter int DWIDTH = mc_cmd_pkg::DWIDTH_DEF
) (
    input  logic               clock_i,
    input  logic               rst_n_i,
    // Host side, rw_i high for a write
    input  logic               req_i,
    input  logic               rw_i,
    input  logic [AWIDTH-1:0]  addr_i,
    input  logic [DWIDTH-1:0]  data_i,
    output logic               ready_o,
    output logic               valid_o,
    output logic [DWIDTH-1:0]  data_o,
    // Toward the arbiter
    output logic               cmd_valid_o,
    output mc_cmd_pkg::mc_op_e cmd_op_o,
    output logic [AWIDTH-1:0]  cmd_addr_o,
    output logic [DWIDTH-1:0]  cmd_wdata_o,
    input  logic               cmd_take_i,
    input  logic               rd_valid_i,
    input  logic [DWIDTH-1:0]  rd_data_i
);
    import mc_cmd_pkg::*;

    typedef enum logic [1:0] {
        HP_IDLE  = 2'd0,
        HP_ISSUE = 2'd1,
        HP_WAIT  = 2'd2
    } hp_state_e;

    hp_state_e          state_q;
    mc_op_e             op_q;
    logic [AWIDTH-1:0]  addr_q;
    logic [DWIDTH-1:0]  wdata_q;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= HP_IDLE;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state_q)
                HP_IDLE: begin
                    if (req_i) begin
                        state_q <= HP_ISSUE;
                    end
                end
                HP_ISSUE: begin
                    // A write is done once the arbiter has it
                    if (cmd_take_i) begin
                        state_q <= (op_q == OP_WRITE) ? HP_IDLE : HP_WAIT;
                    end
                end
                HP_WAIT: begin
                    if (rd_valid_i) begin
                        state_q <= HP_IDLE;
                        valid_o <= 1'b1;
                    end
                end
                default: state_q <= HP_IDLE;
            endcase
        end
    end

    // Latched request and returned word
    always_ff @(posedge clock_i) begin
        if (ready_o && req_i) begin
            op_q    <= rw_i ? OP_WRITE : OP_READ;
            addr_q  <= addr_i;
            wdata_q <= data_i;
        end
        if (rd_valid_i && (state_q == HP_WAIT)) begin
            data_o <= rd_data_i;
        end
    end

    assign ready_o     = (state_q == HP_IDLE);
    assign cmd_valid_o = (state_q == HP_ISSUE);
    assign cmd_op_o    = op_q;
    assign cmd_addr_o  = addr_q;
    assign cmd_wdata_o = wdata_q;

    // Read data only returns for a read this port has issued
    a_rd_in_wait: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        rd_valid_i |-> (state_q == HP_WAIT));

endmodule

// File: pattern_gen.sv
// Self-test source writing pseudorandom words over the memory, then reading them back
`timescale 1ns/1ns

module pattern_gen #(
    parameter int AWIDTH = mc_cmd_pkg::AWIDTH_DEF,
    parameter int DWIDTH = mc_cmd_pkg::DWIDTH_DEF
) (
    input  logic               clock_i,
    input  logic               rst_n_i,
    input  logic               test_mode_i,
    output logic               cmd_valid_o,
    output mc_cmd_pkg::mc_op_e cmd_op_o,
    output logic [AWIDTH-1:0]  cmd_addr_o,
    output logic [DWIDTH-1:0]  cmd_wdata_o,
    input  logic               cmd_take_i,
    input  logic               rd_valid_i
);
    import mc_cmd_pkg::*;
    import mc_test_pkg::*;

    gen_state_e         state_q;
    logic [AWIDTH-1:0]  addr_q;
    logic [AWIDTH-1:0]  rd_cnt_q;
    logic [31:0]        lfsr_q;
    logic               last_addr;
    logic               last_rd;

    assign last_addr = &addr_q;
    assign last_rd   = rd_valid_i && (&rd_cnt_q);

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= GEN_IDLE;
            addr_q   <= '0;
            rd_cnt_q <= '0;
            lfsr_q   <= LFSR_SEED;
        end else begin
            // Returns may start arriving while reads are still being issued
            if (rd_valid_i) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
            case (state_q)
                GEN_IDLE: begin
                    if (test_mode_i) begin
                        state_q <= GEN_WRITE;
                    end
                end
                GEN_WRITE: begin
                    if (cmd_take_i) begin
                        lfsr_q <= lfsr_step(lfsr_q);
                        addr_q <= addr_q + 1'b1;
                        if (last_addr) begin
                            state_q <= GEN_READ;
                        end
                    end
                end
                GEN_READ: begin
                    if (cmd_take_i) begin
                        addr_q <= addr_q + 1'b1;
                        if (last_addr) begin
                            state_q <= GEN_DRAIN;
                        end
                    end
                end
                GEN_DRAIN: begin
                    // Next pass continues the sequence
                    if (last_rd) begin
                        state_q <= GEN_WRITE;
                    end
                end
                default: state_q <= GEN_IDLE;
            endcase
        end
    end

    assign cmd_valid_o = (state_q == GEN_WRITE) || (state_q == GEN_READ);
    assign cmd_op_o    = (state_q == GEN_WRITE) ? OP_WRITE : OP_READ;
    assign cmd_addr_o  = addr_q;
    // Low bits of the sequence, DWIDTH up to 32
    assign cmd_wdata_o = lfsr_q[DWIDTH-1:0];

endmodule

// File: pattern_chk.sv
// Self-test checker replaying the pattern sequence against read data
`timescale 1ns/1ns

module pattern_chk #(
    parameter int AWIDTH = mc_cmd_pkg::AWIDTH_DEF,
    parameter int DWIDTH = mc_cmd_pkg::DWIDTH_DEF
) (
    input  logic              clock_i,
    input  logic              rst_n_i,
    input  logic              rd_valid_i,
    input  logic [DWIDTH-1:0] rd_data_i,
    output logic              test_fail_o,
    output logic [15:0]       pass_cnt_o
);
    import mc_test_pkg::*;

    logic [31:0]        exp_q;
    logic [AWIDTH-1:0]  word_cnt_q;
    logic               pass_err_q;
    logic               mismatch;

    assign mismatch = rd_valid_i && (rd_data_i != exp_q[DWIDTH-1:0]);

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_q       <= LFSR_SEED;
            word_cnt_q  <= '0;
            pass_err_q  <= 1'b0;
            test_fail_o <= 1'b0;
            pass_cnt_o  <= '0;
        end else if (rd_valid_i) begin
            exp_q      <= lfsr_step(exp_q);
            word_cnt_q <= word_cnt_q + 1'b1;
            if (mismatch) begin
                test_fail_o <= 1'b1;
            end
            // Last word of a pass closes it out
            if (&word_cnt_q) begin
                pass_err_q <= 1'b0;
                if (!pass_err_q && !mismatch) begin
                    pass_cnt_o <= pass_cnt_o + 1'b1;
                end
            end else if (mismatch) begin
                pass_err_q <= 1'b1;
            end
        end
    end

endmodule

// File: cmd_arbiter.sv
// Command arbiter selecting host or self-test source and spending memory credits
`timescale 1ns/1ns

module cmd_arbiter #(
    parameter int AWIDTH    = mc_cmd_pkg::AWIDTH_DEF,
    parameter int DWIDTH    = mc_cmd_pkg::DWIDTH_DEF,
    parameter int CMD_DEPTH = mc_cmd_pkg::CMD_DEPTH_DEF
) (
    input  logic               clock_i,
    input  logic               rst_n_i,
    input  logic               test_mode_i,
    // Host source
    input  logic               host_cmd_valid_i,
    input  mc_cmd_pkg::mc_op_e host_cmd_op_i,
    input  logic [AWIDTH-1:0]  host_cmd_addr_i,
    input  logic [DWIDTH-1:0]  host_cmd_wdata_i,
    output logic               host_cmd_take_o,
    output logic               host_rd_valid_o,
    output logic [DWIDTH-1:0]  host_rd_data_o,
    // Pattern generator source
    input  logic               gen_cmd_valid_i,
    input  mc_cmd_pkg::mc_op_e gen_cmd_op_i,
    input  logic [AWIDTH-1:0]  gen_cmd_addr_i,
    input  logic [DWIDTH-1:0]  gen_cmd_wdata_i,
    output logic               gen_cmd_take_o,
    output logic               gen_rd_valid_o,
    output logic [DWIDTH-1:0]  gen_rd_data_o,
    // Memory side
    output logic               mem_cmd_valid_o,
    output mc_cmd_pkg::mc_op_e mem_cmd_op_o,
    output logic [AWIDTH-1:0]  mem_cmd_addr_o,
    output logic [DWIDTH-1:0]  mem_cmd_wdata_o,
    input  logic               mem_credit_i,
    input  logic               mem_rd_valid_i,
    input  logic [DWIDTH-1:0]  mem_rd_data_i
);
    import mc_cmd_pkg::*;

    localparam int CW = $clog2(CMD_DEPTH + 1);

    logic [CW-1:0] credit_q;
    logic          src_valid;
    logic          send;

    ////////////////////
    // Source select
    assign src_valid       = test_mode_i ? gen_cmd_valid_i : host_cmd_valid_i;
    assign send            = src_valid && (credit_q != '0);
    assign mem_cmd_valid_o = send;
    assign mem_cmd_op_o    = test_mode_i ? gen_cmd_op_i : host_cmd_op_i;
    assign mem_cmd_addr_o  = test_mode_i ? gen_cmd_addr_i : host_cmd_addr_i;
    assign mem_cmd_wdata_o = test_mode_i ? gen_cmd_wdata_i : host_cmd_wdata_i;
    assign host_cmd_take_o = send && !test_mode_i;
    assign gen_cmd_take_o  = send && test_mode_i;

    // Read returns go to whoever owns the mode
    assign host_rd_valid_o = mem_rd_valid_i && !test_mode_i;
    assign gen_rd_valid_o  = mem_rd_valid_i && test_mode_i;
    assign host_rd_data_o  = mem_rd_data_i;
    assign gen_rd_data_o   = mem_rd_data_i;

    ////////////////////
    // Credits, one per queue entry
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= CW'(CMD_DEPTH);
        end else begin
            credit_q <= credit_q - CW'(send) + CW'(mem_credit_i);
        end
    end

    // A wrap below zero would also land above CMD_DEPTH
    a_credit_range: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        credit_q <= CW'(CMD_DEPTH));

    a_mode_stable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        $stable(test_mode_i));

    // Every read return traces back to a pop RD_LATENCY cycles earlier
    a_rd_latency: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        mem_rd_valid_i |-> $past(mem_credit_i, RD_LATENCY));

endmodule

// File: burst_mem.sv
// Word memory stand-in with a credit-returning command queue and fixed read latency
`timescale 1ns/1ns

module burst_mem #(
    parameter int AWIDTH    = mc_cmd_pkg::AWIDTH_DEF,
    parameter int DWIDTH    = mc_cmd_pkg::DWIDTH_DEF,
    parameter int CMD_DEPTH = mc_cmd_pkg::CMD_DEPTH_DEF
) (
    input  logic               clock_i,
    input  logic               rst_n_i,
    input  logic               refresh_i,
    input  logic               cmd_valid_i,
    input  mc_cmd_pkg::mc_op_e cmd_op_i,
    input  logic [AWIDTH-1:0]  cmd_addr_i,
    input  logic [DWIDTH-1:0]  cmd_wdata_i,
    output logic               credit_o,
    output logic               rd_valid_o,
    output logic [DWIDTH-1:0]  rd_data_o
);
    import mc_cmd_pkg::*;

    localparam int PW = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CW = $clog2(CMD_DEPTH + 1);

    // Command queue
    mc_op_e             q_op   [CMD_DEPTH];
    logic [AWIDTH-1:0]  q_addr [CMD_DEPTH];
    logic [DWIDTH-1:0]  q_data [CMD_DEPTH];
    logic [PW-1:0]      wr_ptr_q;
    logic [PW-1:0]      rd_ptr_q;
    logic [CW-1:0]      count_q;
    logic               pop;

    // Array and read pipeline
    logic [DWIDTH-1:0]     mem_q    [2**AWIDTH];
    logic [RD_LATENCY-1:0] pipe_v_q;
    logic [DWIDTH-1:0]     pipe_d_q [RD_LATENCY];

    // Refresh holds the queue, which starves the arbiter of credits
    assign pop      = (count_q != '0) && !refresh_i;
    assign credit_o = pop;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            pipe_v_q <= '0;
        end else begin
            if (cmd_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PW'(CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PW'(CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q     <= count_q + CW'(cmd_valid_i) - CW'(pop);
            pipe_v_q[0] <= pop && (q_op[rd_ptr_q] == OP_READ);
            for (int i = 1; i < RD_LATENCY; i++) begin
                pipe_v_q[i] <= pipe_v_q[i-1];
            end
        end
    end

    ////////////////////
    // Payload and array
    always_ff @(posedge clock_i) begin
        if (cmd_valid_i) begin
            q_op[wr_ptr_q]   <= cmd_op_i;
            q_addr[wr_ptr_q] <= cmd_addr_i;
            q_data[wr_ptr_q] <= cmd_wdata_i;
        end
        // Writes land at the pop
        if (pop && (q_op[rd_ptr_q] == OP_WRITE)) begin
            mem_q[q_addr[rd_ptr_q]] <= q_data[rd_ptr_q];
        end
        pipe_d_q[0] <= mem_q[q_addr[rd_ptr_q]];
        for (int i = 1; i < RD_LATENCY; i++) begin
            pipe_d_q[i] <= pipe_d_q[i-1];
        end
    end

    assign rd_valid_o = pipe_v_q[RD_LATENCY-1];
    assign rd_data_o  = pipe_d_q[RD_LATENCY-1];

    // Credit accounting upstream must keep the queue from overflowing
    a_no_push_full: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        cmd_valid_i |-> (count_q != CW'(CMD_DEPTH)));

endmodule

// File: mem_ctrl_top.sv
// Memory controller top level with host port, self-test pair, arbiter and memory
`timescale 1ns/1ns

module mem_ctrl_top #(
    parameter int AWIDTH    = mc_cmd_pkg::AWIDTH_DEF,
    parameter int DWIDTH    = mc_cmd_pkg::DWIDTH_DEF,
    parameter int CMD_DEPTH = mc_cmd_pkg::CMD_DEPTH_DEF
) (
    input  logic              clock_i,
    input  logic              rst_n_i,
    input  logic              test_mode_i,
    input  logic              refresh_i,
    // Host bus
    input  logic              req_i,
    input  logic              rw_i,
    input  logic [AWIDTH-1:0] addr_i,
    input  logic [DWIDTH-1:0] data_i,
    output logic              ready_o,
    output logic              valid_o,
    output logic [DWIDTH-1:0] data_o,
    // Self-test status
    output logic              test_fail_o,
    output logic [15:0]       pass_cnt_o
);
    import mc_cmd_pkg::*;

    logic               host_cmd_valid;
    mc_op_e             host_cmd_op;
    logic [AWIDTH-1:0]  host_cmd_addr;
    logic [DWIDTH-1:0]  host_cmd_wdata;
    logic               host_cmd_take;
    logic               host_rd_valid;
    logic [DWIDTH-1:0]  host_rd_data;

    logic               gen_cmd_valid;
    mc_op_e             gen_cmd_op;
    logic [AWIDTH-1:0]  gen_cmd_addr;
    logic [DWIDTH-1:0]  gen_cmd_wdata;
    logic               gen_cmd_take;
    logic               gen_rd_valid;
    logic [DWIDTH-1:0]  gen_rd_data;

    logic               mem_cmd_valid;
    mc_op_e             mem_cmd_op;
    logic [AWIDTH-1:0]  mem_cmd_addr;
    logic [DWIDTH-1:0]  mem_cmd_wdata;
    logic               mem_credit;
    logic               mem_rd_valid;
    logic [DWIDTH-1:0]  mem_rd_data;

    ////////////////////
    // Command sources
    host_cmd_port #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) host_cmd_port_inst (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .rw_i        (rw_i),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .data_o      (data_o),
        .cmd_valid_o (host_cmd_valid),
        .cmd_op_o    (host_cmd_op),
        .cmd_addr_o  (host_cmd_addr),
        .cmd_wdata_o (host_cmd_wdata),
        .cmd_take_i  (host_cmd_take),
        .rd_valid_i  (host_rd_valid),
        .rd_data_i   (host_rd_data)
    );

    pattern_gen #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) pattern_gen_inst (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .test_mode_i (test_mode_i),
        .cmd_valid_o (gen_cmd_valid),
        .cmd_op_o    (gen_cmd_op),
        .cmd_addr_o  (gen_cmd_addr),
        .cmd_wdata_o (gen_cmd_wdata),
        .cmd_take_i  (gen_cmd_take),
        .rd_valid_i  (gen_rd_valid)
    );

    ////////////////////
    // Arbiter and memory
    cmd_arbiter #(
        .AWIDTH    (AWIDTH),
        .DWIDTH    (DWIDTH),
        .CMD_DEPTH (CMD_DEPTH)
    ) cmd_arbiter_inst (
        .clock_i          (clock_i),
        .rst_n_i          (rst_n_i),
        .test_mode_i      (test_mode_i),
        .host_cmd_valid_i (host_cmd_valid),
        .host_cmd_op_i    (host_cmd_op),
        .host_cmd_addr_i  (host_cmd_addr),
        .host_cmd_wdata_i (host_cmd_wdata),
        .host_cmd_take_o  (host_cmd_take),
        .host_rd_valid_o  (host_rd_valid),
        .host_rd_data_o   (host_rd_data),
        .gen_cmd_valid_i  (gen_cmd_valid),
        .gen_cmd_op_i     (gen_cmd_op),
        .gen_cmd_addr_i   (gen_cmd_addr),
        .gen_cmd_wdata_i  (gen_cmd_wdata),
        .gen_cmd_take_o   (gen_cmd_take),
        .gen_rd_valid_o   (gen_rd_valid),
        .gen_rd_data_o    (gen_rd_data),
        .mem_cmd_valid_o  (mem_cmd_valid),
        .mem_cmd_op_o     (mem_cmd_op),
        .mem_cmd_addr_o   (mem_cmd_addr),
        .mem_cmd_wdata_o  (mem_cmd_wdata),
        .mem_credit_i     (mem_credit),
        .mem_rd_valid_i   (mem_rd_valid),
        .mem_rd_data_i    (mem_rd_data)
    );

    burst_mem #(
        .AWIDTH    (AWIDTH),
        .DWIDTH    (DWIDTH),
        .CMD_DEPTH (CMD_DEPTH)
    ) burst_mem_inst (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .refresh_i   (refresh_i),
        .cmd_valid_i (mem_cmd_valid),
        .cmd_op_i    (mem_cmd_op),
        .cmd_addr_i  (mem_cmd_addr),
        .cmd_wdata_i (mem_cmd_wdata),
        .credit_o    (mem_credit),
        .rd_valid_o  (mem_rd_valid),
        .rd_data_o   (mem_rd_data)
    );

    // Checker taps the generator's read returns
    pattern_chk #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) pattern_chk_inst (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .rd_valid_i  (gen_rd_valid),
        .rd_data_i   (gen_rd_data),
        .test_fail_o (test_fail_o),
        .pass_cnt_o  (pass_cnt_o)
    );

endmodule

// File: mem_ctrl_tb.sv
// Testbench for the memory controller covering host traffic, refresh stalls and self-test
`timescale 1ns/1ns

module mem_ctrl_tb;

    localparam int AWIDTH       = 6;
    localparam int DWIDTH       = 32;
    localparam int CMD_DEPTH    = 4;
    localparam int WORDS        = 2 ** AWIDTH;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_REQS    = 200;
    localparam int REFRESH_HOLD = 40;
    localparam int PASS_TARGET  = 3;
    // Generous worst case for one host request under random refresh
    localparam int REQ_CYCLES   = 30;
    localparam int HOST_REQS    = WORDS + 4 + RAND_REQS + 10;
    // One self-test pass moves 2*WORDS commands plus the drain
    localparam int PASS_CYCLES  = 8 * WORDS;
    localparam int CYCLE_LIMIT  = 4 * RESET_CYCLES + HOST_REQS * REQ_CYCLES
                                + 2 * REFRESH_HOLD + (PASS_TARGET + 1) * PASS_CYCLES;

    logic              clock_i;
    logic              rst_n_i;
    logic              test_mode_i;
    logic              refresh_i;
    logic              req_i;
    logic              rw_i;
    logic [AWIDTH-1:0] addr_i;
    logic [DWIDTH-1:0] data_i;
    logic              ready_o;
    logic              valid_o;
    logic [DWIDTH-1:0] data_o;
    logic              test_fail_o;
    logic [15:0]       pass_cnt_o;

    integer            seed;
    int                cycle_cnt;
    int                errors;
    int                checks;
    int                tests;
    int                failed_tests;
    int                valid_seen;
    int                reads_acc;
    // 0 low, 1 random, 2 held high
    int                refresh_mode;
    logic [DWIDTH-1:0] model [WORDS];

    mem_ctrl_top #(
        .AWIDTH    (AWIDTH),
        .DWIDTH    (DWIDTH),
        .CMD_DEPTH (CMD_DEPTH)
    ) mem_ctrl_top_inst (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .test_mode_i (test_mode_i),
        .refresh_i   (refresh_i),
        .req_i       (req_i),
        .rw_i        (rw_i),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .data_o      (data_o),
        .test_fail_o (test_fail_o),
        .pass_cnt_o  (pass_cnt_o)
    );

    always #5 clock_i = ~clock_i;

    // Watchdog
    always @(posedge clock_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    function automatic logic [DWIDTH-1:0] fill_word(input logic [AWIDTH-1:0] a);
        return 32'h5A00_0000 ^ (DWIDTH'(a) * 32'h0004_0401);
    endfunction

    task automatic check_val(input string name, input logic [DWIDTH-1:0] exp,
                             input logic [DWIDTH-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("Test %s ok", name);
        end else begin
            failed_tests++;
            $display("Test %s had %0d errors", name, errors - err_start);
        end
    endtask

    // Moves to the next falling edge, counts valid pulses, drives refresh
    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clock_i);
        if (valid_o) begin
            valid_seen++;
        end
        case (refresh_mode)
            1: begin
                rnd       = $random(seed);
                refresh_i = (rnd[1:0] == 2'b00);
            end
            2: refresh_i = 1'b1;
            default: refresh_i = 1'b0;
        endcase
    endtask

    task automatic apply_reset(input logic mode);
        @(negedge clock_i);
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        refresh_mode = 0;
        refresh_i    = 1'b0;
        test_mode_i  = mode;
        repeat (RESET_CYCLES) begin
            next_cycle();
        end
        rst_n_i = 1'b1;
        next_cycle();
    endtask

    // One full host transaction, called on a falling edge
    task automatic host_access(input string name, input logic wr,
                               input logic [AWIDTH-1:0] addr, input logic [DWIDTH-1:0] wdata);
        logic [DWIDTH-1:0] exp;
        req_i  = 1'b1;
        rw_i   = wr;
        addr_i = addr;
        data_i = wdata;
        while (!ready_o) begin
            next_cycle();
        end
        // Taken at the coming rising edge
        exp = model[addr];
        if (wr) begin
            model[addr] = wdata;
        end else begin
            reads_acc++;
        end
        next_cycle();
        req_i = 1'b0;
        if (wr) begin
            while (!ready_o) begin
                next_cycle();
            end
        end else begin
            while (!valid_o) begin
                next_cycle();
            end
            check_val(name, exp, data_o);
        end
    endtask

    ////////////////////
    // Test sequence
    initial begin
        logic [31:0]       rnd;
        int                err_start;
        int                valid_start;
        int                reads_start;
        logic              pend_read;
        logic [DWIDTH-1:0] pend_exp;
        logic              fail_seen;
        logic [AWIDTH-1:0] bp_addrs [$];

        seed         = 32'h8c42_f96e;
        clock_i      = 1'b0;
        rst_n_i      = 1'b0;
        test_mode_i  = 1'b0;
        refresh_i    = 1'b0;
        req_i        = 1'b0;
        rw_i         = 1'b0;
        addr_i       = '0;
        data_i       = '0;
        cycle_cnt    = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        valid_seen   = 0;
        reads_acc    = 0;
        refresh_mode = 0;

        apply_reset(1'b0);
        err_start = errors;
        check_val("reset ready_o", 1, ready_o);
        check_val("reset valid_o", 0, valid_o);
        check_val("reset test_fail_o", 0, test_fail_o);
        check_val("reset pass_cnt_o", 0, pass_cnt_o);
        report_test("reset", err_start);

        // Every word gets a known value first
        err_start = errors;
        for (int a = 0; a < WORDS; a++) begin
            host_access("fill", 1'b1, AWIDTH'(a), fill_word(AWIDTH'(a)));
        end
        host_access("fill readback", 1'b0, '0, '0);
        host_access("fill readback", 1'b0, AWIDTH'(WORDS - 1), '0);
        report_test("fill", err_start);

        err_start   = errors;
        valid_start = valid_seen;
        host_access("directed", 1'b1, AWIDTH'(42), 32'hDEAD_BEEF);
        host_access("directed", 1'b0, AWIDTH'(42), '0);
        next_cycle();
        check_val("directed valid_o pulses", 1, valid_seen - valid_start);
        report_test("directed", err_start);

        err_start    = errors;
        valid_start  = valid_seen;
        reads_start  = reads_acc;
        refresh_mode = 1;
        for (int n = 0; n < RAND_REQS; n++) begin
            rnd = $random(seed);
            host_access("random", rnd[0], rnd[AWIDTH:1], $random(seed));
        end
        next_cycle();
        check_val("random valid_o pulses", reads_acc - reads_start, valid_seen - valid_start);
        report_test("random", err_start);

        // Refresh stall with the host still pushing
        err_start    = errors;
        valid_start  = valid_seen;
        pend_read    = 1'b0;
        pend_exp     = '0;
        bp_addrs.delete();
        refresh_mode = 2;
        for (int c = 0; c < REFRESH_HOLD; c++) begin
            next_cycle();
            req_i = 1'b0;
            if (ready_o && !pend_read) begin
                rnd    = $random(seed);
                req_i  = 1'b1;
                rw_i   = rnd[0];
                addr_i = rnd[AWIDTH:1];
                data_i = $random(seed);
                if (rnd[0]) begin
                    model[addr_i] = data_i;
                    bp_addrs.push_back(addr_i);
                end else begin
                    pend_read = 1'b1;
                    pend_exp  = model[addr_i];
                    reads_acc++;
                end
            end
        end
        next_cycle();
        req_i = 1'b0;
        check_val("backpressure valid_o pulses", 0, valid_seen - valid_start);
        check_val("backpressure ready_o", 0, ready_o);
        refresh_mode = 0;
        if (pend_read) begin
            while (!valid_o) begin
                next_cycle();
            end
            check_val("backpressure read", pend_exp, data_o);
        end else begin
            while (!ready_o) begin
                next_cycle();
            end
        end
        foreach (bp_addrs[i]) begin
            host_access("backpressure readback", 1'b0, bp_addrs[i], '0);
        end
        report_test("backpressure", err_start);

        // Self-test runs on its own after a reset in test mode
        err_start = errors;
        apply_reset(1'b1);
        refresh_mode = 1;
        fail_seen    = 1'b0;
        while ((pass_cnt_o < 16'(PASS_TARGET)) && !fail_seen) begin
            next_cycle();
            if (test_fail_o !== 1'b0) begin
                fail_seen = 1'b1;
            end
        end
        check_val("selftest test_fail_o", 0, fail_seen);
        checks++;
        assert (pass_cnt_o >= 16'(PASS_TARGET)) else begin
            $display("Self-test stopped at %0d clean passes after a pattern mismatch",
                     pass_cnt_o);
            errors++;
        end
        report_test("selftest", err_start);

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: mem_ctrl_top.f
mc_cmd_pkg.sv
mc_test_pkg.sv
host_cmd_port.sv
pattern_gen.sv
pattern_chk.sv
cmd_arbiter.sv
burst_mem.sv
mem_ctrl_top.sv
mem_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_ctrl_tb \
    -f mem_ctrl_top.f -o mem_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0
